//--- sim/ace_golden.mem
// kind_addr_data_columnas_ear_expected
// kind 0 mem write, 1 mem read, 2 io write, 3 io read, 4 video read, F end
// Screen, char, user and expansion RAM
0_2005_A5_00_0_00
0_2805_3C_00_0_00
1_2005_00_00_0_A5
1_2405_00_00_0_A5
1_2805_00_00_0_3C
0_3C10_77_00_0_00
1_3C10_00_00_0_77
0_4123_5A_00_0_00
0_7FFF_E1_00_0_00
1_4123_00_00_0_5A
1_7FFF_00_00_0_E1
// ROM lock and unlock
1_0100_00_00_0_00
0_0100_AB_00_0_00
1_0100_00_00_0_00
3_0001_00_00_0_00
2_0001_01_00_0_00
3_0001_00_00_0_01
0_0100_AB_00_0_00
1_0100_00_00_0_AB
2_0001_00_00_0_00
0_0100_CD_00_0_00
1_0100_00_00_0_AB
// External window
0_8010_96_00_0_00
0_C123_4E_00_0_00
1_8010_00_00_0_96
1_C123_00_00_0_4E
// Keyboard port, expected is {spk, mic} on writes
3_FEFE_00_1E_1_FE
3_7FFE_00_0B_0_CB
2_00FE_08_00_0_03
3_BFFE_00_15_1_F5
2_00FE_00_00_0_02
3_DFFE_00_1F_0_DF
// Video OR and floating bus
4_0005_00_00_0_BD
0_2010_81_00_0_00
0_2810_18_00_0_00
4_0010_00_00_0_99
1_3000_00_00_0_99
1_3800_00_00_0_99
3_0055_00_00_0_99
F_0000_00_00_0_00

//--- vlog.f
+incdir+src
src/ace_bus_pkg.sv
src/ace_ctrl_pkg.sv
src/ace_bus_control.sv
src/ace_dual_ram.sv
src/ace_sp_ram.sv
src/jupiter_ace_mem.sv
sim/ace_assertions.sv
sim/tb_jupiter_ace_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
   --top-module tb_jupiter_ace_mem -Mdir obj_dir -o tb_jupiter_ace_mem
./obj_dir/tb_jupiter_ace_mem | tee "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
   echo "Testbench reported failure, see $LOG"
   exit 1
fi
echo "Testbench run complete, see $LOG"

//--- sim/tb_jupiter_ace_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "ace_params.svh"

module tb_jupiter_ace_mem;

   localparam int CLK_PERIOD = 8;
   localparam int MAX_VEC    = 64;

   logic                     clk_65;
   logic                     rst;
   ace_bus_pkg::cpu_addr_t   cpu_addr;
   logic                     mreq_n;
   logic                     iorq_n;
   logic                     rd_n;
   logic                     wr_n;
   ace_bus_pkg::data_t       cpu_dout;
   ace_bus_pkg::data_t       cpu_din;
   logic                     wait_n;
   ace_bus_pkg::xram_addr_t  sd_addr;
   ace_bus_pkg::data_t       sd_din;
   logic                     sd_we;
   logic                     sd_rd;
   ace_bus_pkg::data_t       sd_dout;
   logic                     sd_ready;
   ace_bus_pkg::kbd_row_t    filas;
   ace_bus_pkg::kbd_col_t    columnas;
   logic                     ear;
   logic                     mic;
   logic                     spk;
   ace_bus_pkg::ram1k_addr_t vid_screen_addr;
   ace_bus_pkg::ram1k_addr_t vid_char_addr;
   ace_bus_pkg::data_t       vid_data;

   // kind, addr, data, columnas, ear, expected
   logic [47:0]              vecs [0:MAX_VEC-1];
   ace_bus_pkg::data_t       ext_mem [0:(1 << `ACE_XRAM_AW)-1];
   ace_bus_pkg::xram_addr_t  last_wr_addr;
   logic [15:0]              lfsr;
   int                       vec_count;
   int                       ext_count;
   int                       errors;
   logic                     vec_bad;
   // Values caught at the end of a bus cycle
   ace_bus_pkg::data_t       smp_din;
   ace_bus_pkg::kbd_row_t    smp_row;
   logic                     smp_spk;
   logic                     smp_mic;
   logic                     smp_wait_low;
   logic                     smp_ready;

   jupiter_ace_mem u_jupiter_ace_mem (
      .clk_65(clk_65), .rst(rst), .cpu_addr(cpu_addr), .mreq_n(mreq_n), .iorq_n(iorq_n),
      .rd_n(rd_n), .wr_n(wr_n), .cpu_dout(cpu_dout), .cpu_din(cpu_din), .wait_n(wait_n),
      .sd_addr(sd_addr), .sd_din(sd_din), .sd_we(sd_we), .sd_rd(sd_rd), .sd_dout(sd_dout),
      .sd_ready(sd_ready), .filas(filas), .columnas(columnas), .ear(ear), .mic(mic),
      .spk(spk), .vid_screen_addr(vid_screen_addr), .vid_char_addr(vid_char_addr),
      .vid_data(vid_data)
   );

   initial begin
      clk_65 = 1'b0;
      forever #(CLK_PERIOD / 2) clk_65 = ~clk_65;
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   // Three bits per try, zero is retried
   task pick_delay(output int d);
      d = 0;
      while (d == 0) begin
         for (int i = 0; i < 3; i++) begin
            lfsr = lfsr_next(lfsr);
            d = d * 2 + int'(lfsr[0]);
         end
      end
   endtask

   task report_mismatch(input string name, input logic [15:0] got, input logic [15:0] exp);
      errors++;
      vec_bad = 1'b1;
      $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
   endtask

   task report_text(input string msg);
      errors++;
      vec_bad = 1'b1;
      $display("Error at t=%0t: %s", $time, msg);
   endtask

   task bus_cycle(input logic io, input logic write, input ace_bus_pkg::cpu_addr_t addr,
                  input ace_bus_pkg::data_t data, input ace_bus_pkg::kbd_col_t col,
                  input logic ear_in);
      @(posedge clk_65);
      cpu_addr <= addr;
      cpu_dout <= data;
      columnas <= col;
      ear      <= ear_in;
      mreq_n   <= io;
      iorq_n   <= !io;
      rd_n     <= write;
      wr_n     <= !write;
      // Decode edge, wait_n drops here for the external window
      @(posedge clk_65);
      @(negedge clk_65);
      smp_wait_low = !wait_n;
      repeat (2) @(posedge clk_65);
      @(negedge clk_65);
      while (!wait_n) @(negedge clk_65);
      smp_ready = sd_ready;
      smp_din   = cpu_din;
      smp_row   = filas;
      smp_spk   = spk;
      smp_mic   = mic;
      @(posedge clk_65);
      mreq_n <= 1'b1;
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      wr_n   <= 1'b1;
   endtask

   task video_read(input ace_bus_pkg::ram1k_addr_t a);
      @(posedge clk_65);
      vid_screen_addr <= a;
      vid_char_addr   <= a;
      @(posedge clk_65);
      @(negedge clk_65);
      smp_din = vid_data;
   endtask

   ////////////////////
   // External RAM model
   ////////////////////
   initial begin
      int d;
      lfsr     = 16'd41539;
      sd_ready = 1'b0;
      sd_dout  = 8'h00;
      for (int i = 0; i < (1 << `ACE_XRAM_AW); i++)
         ext_mem[i] = i[7:0] ^ {2'b00, i[13:8]};
      forever begin
         @(negedge clk_65);
         if (sd_rd && !sd_ready) begin
            pick_delay(d);
            repeat (d) @(posedge clk_65);
            if (sd_we) begin
               ext_mem[sd_addr] = sd_din;
               last_wr_addr     = sd_addr;
            end
            sd_dout  <= ext_mem[sd_addr];
            sd_ready <= 1'b1;
            @(negedge clk_65);
            while (sd_rd) @(negedge clk_65);
            @(posedge clk_65);
            sd_ready <= 1'b0;
         end
      end
   end

   // Watchdog sized from the vector count
   initial begin
      int limit;
      #1;
      limit = 12 + vec_count * 20 + ext_count * 7;
      repeat (limit) @(posedge clk_65);
      $display("Timeout: no result after %0d cycles", limit);
      $display("Simulation finished: FAIL");
      $finish;
   end

   ////////////////////
   // Vector loop
   ////////////////////
   initial begin
      logic [47:0]            v;
      logic [3:0]             kind;
      ace_bus_pkg::cpu_addr_t addr;
      ace_bus_pkg::data_t     data;
      ace_bus_pkg::data_t     exp;
      logic                   is_ext;
      int                     passed;
      rst             = 1'b1;
      cpu_addr        = 16'h0000;
      mreq_n          = 1'b1;
      iorq_n          = 1'b1;
      rd_n            = 1'b1;
      wr_n            = 1'b1;
      cpu_dout        = 8'h00;
      columnas        = 5'h1F;
      ear             = 1'b0;
      vid_screen_addr = '0;
      vid_char_addr   = '0;
      errors          = 0;
      passed          = 0;
      for (int i = 0; i < MAX_VEC; i++)
         vecs[i] = '1;
      $readmemh("sim/ace_golden.mem", vecs);
      vec_count = 0;
      ext_count = 0;
      while (vec_count < MAX_VEC && vecs[vec_count][47:44] != 4'hF) begin
         if (vecs[vec_count][47:44] <= 4'h1 && vecs[vec_count][43:28] >= `ACE_EXT_BASE)
            ext_count++;
         vec_count++;
      end
      if (vec_count == 0)
         report_text("no vectors loaded from sim/ace_golden.mem");
      repeat (8) @(posedge clk_65);
      rst <= 1'b0;

      for (int n = 0; n < vec_count; n++) begin
         v       = vecs[n];
         kind    = v[47:44];
         addr    = v[43:28];
         data    = v[27:20];
         exp     = v[7:0];
         is_ext  = addr >= `ACE_EXT_BASE;
         vec_bad = 1'b0;
         case (kind)
            4'h0, 4'h1: begin
               bus_cycle(1'b0, kind == 4'h0, addr, data, v[16:12], v[8]);
               if (is_ext && !smp_wait_low)
                  report_mismatch("wait_n", 16'h1, 16'h0);
               if (!is_ext && smp_wait_low)
                  report_mismatch("wait_n", 16'h0, 16'h1);
               if (is_ext && !smp_ready)
                  report_text("wait_n released without sd_ready");
               if (kind == 4'h1 && smp_din !== exp)
                  report_mismatch("cpu_din", smp_din, exp);
               if (kind == 4'h0 && is_ext && last_wr_addr !== addr[`ACE_XRAM_AW-1:0])
                  report_mismatch("sd_addr", last_wr_addr, addr[`ACE_XRAM_AW-1:0]);
               if (kind == 4'h0 && is_ext && ext_mem[addr[`ACE_XRAM_AW-1:0]] !== data)
                  report_mismatch("sd_din", ext_mem[addr[`ACE_XRAM_AW-1:0]], data);
            end
            4'h2: begin
               bus_cycle(1'b1, 1'b1, addr, data, v[16:12], v[8]);
               if (addr[7:0] == `ACE_KBD_PORT && {smp_spk, smp_mic} !== exp[1:0])
                  report_mismatch("spk/mic", {smp_spk, smp_mic}, exp[1:0]);
            end
            4'h3: begin
               bus_cycle(1'b1, 1'b0, addr, data, v[16:12], v[8]);
               if (smp_din !== exp)
                  report_mismatch("cpu_din", smp_din, exp);
               if (addr[7:0] == `ACE_KBD_PORT && smp_row !== addr[15:8])
                  report_mismatch("filas", smp_row, addr[15:8]);
               if (addr[7:0] == `ACE_KBD_PORT && smp_spk !== 1'b0)
                  report_mismatch("spk", smp_spk, 16'h0);
            end
            4'h4: begin
               video_read(addr[`ACE_RAM1K_AW-1:0]);
               if (smp_din !== exp)
                  report_mismatch("vid_data", smp_din, exp);
            end
            default: report_text("unknown vector kind in golden file");
         endcase
         if (!vec_bad)
            passed++;
         $display("vector %0d kind %0h addr %h: %s", n, kind, addr, vec_bad ? "bad" : "ok");
      end

      $display("%0d vectors, %0d passed, %0d errors", vec_count, passed, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/ace_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module ace_assertions (
   input wire logic                  clk_65,
   input wire logic                  rst,
   input wire logic                  rom_en,
   input wire logic                  screen_en,
   input wire logic                  char_en,
   input wire logic                  user_en,
   input wire logic                  xram_en,
   input wire logic                  sd_rd,
   input wire logic                  mem_we,
   input wire logic                  wait_n,
   input wire ace_ctrl_pkg::region_t region
);

   // One target per bus cycle
   a_one_enable: assert property (@(posedge clk_65) disable iff (rst)
      $onehot0({rom_en, screen_en, char_en, user_en, xram_en, sd_rd}))
      else $error("more than one memory enable high");

   // Only the external window may stall the CPU
   a_wait_ext: assert property (@(posedge clk_65) disable iff (rst)
      !wait_n |-> (sd_rd && region == ace_ctrl_pkg::reg_ext))
      else $error("wait_n low outside an external access");

   a_we_pulse: assert property (@(posedge clk_65) disable iff (rst) mem_we |=> !mem_we)
      else $error("mem_we longer than one cycle");

endmodule

bind ace_bus_control ace_assertions u_ace_assertions (
   .clk_65(clk_65), .rst(rst), .rom_en(rom_en), .screen_en(screen_en), .char_en(char_en),
   .user_en(user_en), .xram_en(xram_en), .sd_rd(sd_rd), .mem_we(mem_we), .wait_n(wait_n),
   .region(region)
);

`default_nettype wire

//--- src/jupiter_ace_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "ace_params.svh"

module jupiter_ace_mem (
   input  wire logic                      clk_65,
   input  wire logic                      rst,
   // Z80 bus
   input  wire ace_bus_pkg::cpu_addr_t    cpu_addr,
   input  wire logic                      mreq_n,
   input  wire logic                      iorq_n,
   input  wire logic                      rd_n,
   input  wire logic                      wr_n,
   input  wire ace_bus_pkg::data_t        cpu_dout,
   output ace_bus_pkg::data_t             cpu_din,
   output wire logic                      wait_n,
   // External RAM
   output wire ace_bus_pkg::xram_addr_t   sd_addr,
   output wire ace_bus_pkg::data_t        sd_din,
   output wire logic                      sd_we,
   output wire logic                      sd_rd,
   input  wire ace_bus_pkg::data_t        sd_dout,
   input  wire logic                      sd_ready,
   // Keyboard and sound
   output wire ace_bus_pkg::kbd_row_t     filas,
   input  wire ace_bus_pkg::kbd_col_t     columnas,
   input  wire logic                      ear,
   output wire logic                      mic,
   output wire logic                      spk,
   // Video
   input  wire ace_bus_pkg::ram1k_addr_t  vid_screen_addr,
   input  wire ace_bus_pkg::ram1k_addr_t  vid_char_addr,
   output wire ace_bus_pkg::data_t        vid_data
);

   ace_ctrl_pkg::region_t    region;
   logic                     rom_en;
   logic                     screen_en;
   logic                     char_en;
   logic                     user_en;
   logic                     xram_en;
   logic                     mem_we;
   ace_bus_pkg::data_t       io_dout;
   ace_bus_pkg::data_t       rom_dout;
   ace_bus_pkg::data_t       screen_dout;
   ace_bus_pkg::data_t       char_dout;
   ace_bus_pkg::data_t       user_dout;
   ace_bus_pkg::data_t       xram_dout;
   ace_bus_pkg::data_t       vid_screen_data;
   ace_bus_pkg::data_t       vid_char_data;
   ace_bus_pkg::ram1k_addr_t ram1k_a;
   ace_bus_pkg::rom_addr_t   rom_a;
   ace_bus_pkg::xram_addr_t  xram_a;

   assign ram1k_a = cpu_addr[`ACE_RAM1K_AW-1:0];
   assign rom_a   = cpu_addr[`ACE_ROM_AW-1:0];
   assign xram_a  = cpu_addr[`ACE_XRAM_AW-1:0];

   assign filas   = cpu_addr[15:8];
   assign sd_addr = xram_a;
   assign sd_din  = cpu_dout;

   // Floating bus on the real machine shows the video fetch
   assign vid_data = vid_screen_data | vid_char_data;

   ace_bus_control u_bus_control (
      .clk_65(clk_65), .rst(rst), .cpu_addr(cpu_addr),
      .mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
      .cpu_dout(cpu_dout), .columnas(columnas), .ear(ear), .sd_ready(sd_ready),
      .region(region), .rom_en(rom_en), .screen_en(screen_en), .char_en(char_en),
      .user_en(user_en), .xram_en(xram_en), .mem_we(mem_we), .io_dout(io_dout),
      .sd_rd(sd_rd), .sd_we(sd_we), .wait_n(wait_n), .mic(mic), .spk(spk)
   );

   ace_dual_ram u_screen_ram (
      .clk_65(clk_65), .ce(screen_en), .we(mem_we), .a1(ram1k_a), .din(cpu_dout),
      .a2(vid_screen_addr), .dout1(screen_dout), .dout2(vid_screen_data)
   );

   ace_dual_ram u_char_ram (
      .clk_65(clk_65), .ce(char_en), .we(mem_we), .a1(ram1k_a), .din(cpu_dout),
      .a2(vid_char_addr), .dout1(char_dout), .dout2(vid_char_data)
   );

   ace_sp_ram #(.ADDR_W(`ACE_RAM1K_AW)) u_user_ram (
      .clk_65(clk_65), .ce(user_en), .we(mem_we), .a(ram1k_a), .din(cpu_dout),
      .dout(user_dout)
   );

   ace_sp_ram #(.ADDR_W(`ACE_XRAM_AW)) u_xram (
      .clk_65(clk_65), .ce(xram_en), .we(mem_we), .a(xram_a), .din(cpu_dout),
      .dout(xram_dout)
   );

   ace_sp_ram #(.ADDR_W(`ACE_ROM_AW)) u_rom (
      .clk_65(clk_65), .ce(rom_en), .we(mem_we), .a(rom_a), .din(cpu_dout),
      .dout(rom_dout)
   );

   ////////////////////
   // CPU read mux
   ////////////////////
   always_ff @(posedge clk_65) begin
      case (region)
         ace_ctrl_pkg::reg_rom:    cpu_din <= rom_dout;
         ace_ctrl_pkg::reg_screen: cpu_din <= screen_dout;
         ace_ctrl_pkg::reg_char:   cpu_din <= char_dout;
         ace_ctrl_pkg::reg_user:   cpu_din <= user_dout;
         ace_ctrl_pkg::reg_xram:   cpu_din <= xram_dout;
         ace_ctrl_pkg::reg_ext: begin
            // Capture once, on the cycle that releases the wait
            if (sd_ready && !wait_n)
               cpu_din <= sd_dout;
         end
         ace_ctrl_pkg::reg_io_kbd,
         ace_ctrl_pkg::reg_io_rom: cpu_din <= io_dout;
         default:                  cpu_din <= vid_data;
      endcase
   end

endmodule

`default_nettype wire

//--- src/ace_sp_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "ace_params.svh"

module ace_sp_ram #(
   parameter int ADDR_W = `ACE_RAM1K_AW
) (
   input  wire logic               clk_65,
   input  wire logic               ce,
   input  wire logic               we,
   input  wire logic [ADDR_W-1:0]  a,
   input  wire ace_bus_pkg::data_t din,
   output ace_bus_pkg::data_t      dout
);

   localparam int DEPTH = 1 << ADDR_W;

   ace_bus_pkg::data_t mem [0:DEPTH-1];

   // Contents start cleared, ROM image arrives over the bus
   initial begin
      for (int i = 0; i < DEPTH; i++)
         mem[i] = '0;
   end

   always_ff @(posedge clk_65) begin
      if (ce) begin
         if (we)
            mem[a] <= din;
         // Old data on a write cycle
         dout <= mem[a];
      end
   end

endmodule

`default_nettype wire

//--- src/ace_dual_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "ace_params.svh"

module ace_dual_ram (
   input  wire logic                     clk_65,
   input  wire logic                     ce,
   input  wire logic                     we,
   input  wire ace_bus_pkg::ram1k_addr_t a1,
   input  wire ace_bus_pkg::data_t       din,
   input  wire ace_bus_pkg::ram1k_addr_t a2,
   output ace_bus_pkg::data_t            dout1,
   output ace_bus_pkg::data_t            dout2
);

   localparam int DEPTH = 1 << `ACE_RAM1K_AW;

   ace_bus_pkg::data_t mem [0:DEPTH-1];

   initial begin
      for (int i = 0; i < DEPTH; i++)
         mem[i] = '0;
   end

   // CPU port
   always_ff @(posedge clk_65) begin
      if (ce) begin
         if (we)
            mem[a1] <= din;
         dout1 <= mem[a1];
      end
   end

   // Video port never stalls
   always_ff @(posedge clk_65) begin
      dout2 <= mem[a2];
   end

endmodule

`default_nettype wire

//--- src/ace_bus_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "ace_params.svh"

module ace_bus_control (
   input  wire  logic                 clk_65,
   input  wire  logic                 rst,
   input  wire  ace_bus_pkg::cpu_addr_t cpu_addr,
   input  wire  logic                 mreq_n,
   input  wire  logic                 iorq_n,
   input  wire  logic                 rd_n,
   input  wire  logic                 wr_n,
   input  wire  ace_bus_pkg::data_t   cpu_dout,
   input  wire  ace_bus_pkg::kbd_col_t columnas,
   input  wire  logic                 ear,
   input  wire  logic                 sd_ready,
   output ace_ctrl_pkg::region_t      region,
   output logic                       rom_en,
   output logic                       screen_en,
   output logic                       char_en,
   output logic                       user_en,
   output logic                       xram_en,
   output logic                       mem_we,
   output ace_bus_pkg::data_t         io_dout,
   output logic                       sd_rd,
   output logic                       sd_we,
   output logic                       wait_n,
   output logic                       mic,
   output logic                       spk
);

   ace_ctrl_pkg::access_state_t state;
   ace_ctrl_pkg::region_t       region_next;
   logic                        cyc_active;
   logic                        we_ok;
   logic                        wr_cycle;
   logic                        rom_wr_unlock;

   function automatic ace_ctrl_pkg::region_t decode(input ace_bus_pkg::cpu_addr_t addr,
                                                    input logic io);
      ace_ctrl_pkg::region_t r;
      r = ace_ctrl_pkg::reg_none;
      if (io) begin
         if (addr[7:0] == `ACE_KBD_PORT)
            r = ace_ctrl_pkg::reg_io_kbd;
         else if (addr[7:0] == `ACE_ROM_UNLOCK_PORT)
            r = ace_ctrl_pkg::reg_io_rom;
      end else if (addr <= `ACE_ROM_END)
         r = ace_ctrl_pkg::reg_rom;
      else if (addr >= `ACE_SCREEN_BASE && addr < `ACE_CHAR_BASE)
         r = ace_ctrl_pkg::reg_screen;
      else if (addr >= `ACE_CHAR_BASE && addr < `ACE_CHAR_BASE + 16'h0800)
         r = ace_ctrl_pkg::reg_char;
      else if (addr >= `ACE_USER_BASE && addr < `ACE_XRAM_BASE)
         r = ace_ctrl_pkg::reg_user;
      else if (addr >= `ACE_XRAM_BASE && addr < `ACE_EXT_BASE)
         r = ace_ctrl_pkg::reg_xram;
      else if (addr >= `ACE_EXT_BASE)
         r = ace_ctrl_pkg::reg_ext;
      return r;
   endfunction

   // A cycle is live while a request strobe and a direction strobe are low
   assign cyc_active  = (!mreq_n || !iorq_n) && (!rd_n || !wr_n);
   assign region_next = decode(cpu_addr, !iorq_n);

   // Locked ROM takes no writes
   always_comb begin
      case (region_next)
         ace_ctrl_pkg::reg_rom:    we_ok = rom_wr_unlock;
         ace_ctrl_pkg::reg_screen,
         ace_ctrl_pkg::reg_char,
         ace_ctrl_pkg::reg_user,
         ace_ctrl_pkg::reg_xram:   we_ok = 1'b1;
         default:                  we_ok = 1'b0;
      endcase
   end

   ////////////////////
   // Access FSM
   ////////////////////
   always_ff @(posedge clk_65) begin
      if (rst) begin
         state         <= ace_ctrl_pkg::st_idle;
         region        <= ace_ctrl_pkg::reg_none;
         rom_en        <= 1'b0;
         screen_en     <= 1'b0;
         char_en       <= 1'b0;
         user_en       <= 1'b0;
         xram_en       <= 1'b0;
         mem_we        <= 1'b0;
         sd_rd         <= 1'b0;
         sd_we         <= 1'b0;
         wait_n        <= 1'b1;
         wr_cycle      <= 1'b0;
         mic           <= 1'b0;
         spk           <= 1'b0;
         rom_wr_unlock <= 1'b0;
      end else begin
         case (state)
            ace_ctrl_pkg::st_idle: begin
               if (cyc_active) begin
                  region    <= region_next;
                  wr_cycle  <= !wr_n;
                  rom_en    <= (region_next == ace_ctrl_pkg::reg_rom) && (wr_n || rom_wr_unlock);
                  screen_en <= region_next == ace_ctrl_pkg::reg_screen;
                  char_en   <= region_next == ace_ctrl_pkg::reg_char;
                  user_en   <= region_next == ace_ctrl_pkg::reg_user;
                  xram_en   <= region_next == ace_ctrl_pkg::reg_xram;
                  mem_we    <= !wr_n && we_ok;
                  if (region_next == ace_ctrl_pkg::reg_ext) begin
                     sd_rd  <= 1'b1;
                     sd_we  <= !wr_n;
                     wait_n <= 1'b0;
                  end
                  state <= ace_ctrl_pkg::st_access;
               end
            end
            ace_ctrl_pkg::st_access: begin
               mem_we <= 1'b0;
               // Port side effects
               if (region == ace_ctrl_pkg::reg_io_kbd) begin
                  if (wr_cycle) begin
                     spk <= 1'b1;
                     mic <= cpu_dout[3];
                  end else
                     spk <= 1'b0;
               end
               if (region == ace_ctrl_pkg::reg_io_rom && wr_cycle)
                  rom_wr_unlock <= cpu_dout[0];
               if (region != ace_ctrl_pkg::reg_ext)
                  state <= ace_ctrl_pkg::st_done;
               else if (sd_ready) begin
                  // External RAM answered at once
                  wait_n <= 1'b1;
                  sd_rd  <= 1'b0;
                  sd_we  <= 1'b0;
                  state  <= ace_ctrl_pkg::st_done;
               end else
                  state <= ace_ctrl_pkg::st_ext_wait;
            end
            ace_ctrl_pkg::st_ext_wait: begin
               if (sd_ready) begin
                  wait_n <= 1'b1;
                  sd_rd  <= 1'b0;
                  sd_we  <= 1'b0;
                  state  <= ace_ctrl_pkg::st_done;
               end
            end
            default: begin
               // Hold enables so the read data stays on the bus
               if (!cyc_active) begin
                  region    <= ace_ctrl_pkg::reg_none;
                  rom_en    <= 1'b0;
                  screen_en <= 1'b0;
                  char_en   <= 1'b0;
                  user_en   <= 1'b0;
                  xram_en   <= 1'b0;
                  state     <= ace_ctrl_pkg::st_idle;
               end
            end
         endcase
      end
   end

   // Port read byte, columns sampled on the access cycle
   always_ff @(posedge clk_65) begin
      if (state == ace_ctrl_pkg::st_access && !wr_cycle) begin
         if (region == ace_ctrl_pkg::reg_io_kbd)
            io_dout <= {2'b11, ear, columnas};
         else if (region == ace_ctrl_pkg::reg_io_rom)
            io_dout <= {7'b0000000, rom_wr_unlock};
      end
   end

endmodule

`default_nettype wire

//--- src/ace_ctrl_pkg.sv
`default_nettype none

package ace_ctrl_pkg;

   // Target of the current bus cycle
   typedef enum logic [3:0] {
      reg_none,
      reg_rom,
      reg_screen,
      reg_char,
      reg_user,
      reg_xram,
      reg_ext,
      reg_io_kbd,
      reg_io_rom
   } region_t;

   // One access from strobe fall to strobe rise
   typedef enum logic [1:0] {
      st_idle,
      st_access,
      st_ext_wait,
      st_done
   } access_state_t;

endpackage

`default_nettype wire

//--- src/ace_bus_pkg.sv
`default_nettype none

`include "ace_params.svh"

package ace_bus_pkg;

   // Z80 side
   typedef logic [15:0] cpu_addr_t;
   typedef logic [7:0]  data_t;

   // Memory address widths
   typedef logic [`ACE_RAM1K_AW-1:0] ram1k_addr_t;
   typedef logic [`ACE_ROM_AW-1:0]   rom_addr_t;
   // Expansion RAM and the external window share this width
   typedef logic [`ACE_XRAM_AW-1:0]  xram_addr_t;

   // Keyboard matrix
   // Rows come from the high address byte
   typedef logic [7:0] kbd_row_t;
   // Columns are active low sense lines
   typedef logic [4:0] kbd_col_t;

endpackage

`default_nettype wire

//--- src/ace_params.svh
`ifndef ACE_PARAMS_SVH
`define ACE_PARAMS_SVH

////////////////////
// Memory map
////////////////////

// ROM occupies 0000 to this address
`define ACE_ROM_END          16'h1FFF
// 2K windows, each mirroring a 1K RAM
`define ACE_SCREEN_BASE      16'h2000
`define ACE_CHAR_BASE        16'h2800
`define ACE_USER_BASE        16'h3C00
`define ACE_XRAM_BASE        16'h4000
// Upper 32K goes out over the sd_ pins
`define ACE_EXT_BASE         16'h8000

// I/O ports, low address byte only
`define ACE_KBD_PORT         8'hFE
`define ACE_ROM_UNLOCK_PORT  8'h01

// Memory address widths
`define ACE_RAM1K_AW         10
`define ACE_ROM_AW           13
`define ACE_XRAM_AW          14

`endif
